// ==== list.f ====
+incdir+common
common/isa_pkg.sv
common/trace_pkg.sv
pipeline/regfile.sv
pipeline/hazard_unit.sv
pipeline/pipe_core.sv
trace/trace_unit.sv
rtl/core_top.sv
verification/tb_core.sv

// ==== verification/tb_core.sv ====
// Retire trace testbench
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module tb_core
    import isa_pkg::*;
    import trace_pkg::*;
();

    localparam int RUN_TIMEOUT    = 5000;  // Cycles allowed per program
    localparam int STARVE_CYCLES  = 40;    // Credit drought length
    localparam int MODE_PROMPT    = 0;
    localparam int MODE_BACKPRESS = 1;
    localparam int MODE_STARVED   = 2;

    logic             clk;
    logic             rst_n;
    logic             run;
    logic             prog_we;
    pc_t              prog_addr;
    logic [`XLEN-1:0] prog_data;
    logic             ret_credit;
    logic             ret_valid;
    seq_id_t          ret_id;
    pc_t              ret_pc;
    logic             ret_we;
    reg_idx_t         ret_rd;
    logic [`XLEN-1:0] ret_wdata;
    logic             halted;

    logic [`XLEN-1:0] prog [`IMEM_DEPTH];
    int               prog_len;
    pc_t              exp_pc [`IMEM_DEPTH];     // Expected retire sequence
    logic             exp_we [`IMEM_DEPTH];
    reg_idx_t         exp_rd [`IMEM_DEPTH];
    logic [`XLEN-1:0] exp_wdata [`IMEM_DEPTH];
    logic             exp_chk [`IMEM_DEPTH];    // HALT data is not compared
    logic [`XLEN-1:0] mregs [`NREGS];           // ISA model state
    logic [`XLEN-1:0] mdmem [`DMEM_DEPTH];

    string test_name;
    int    test_errs;
    int    tests_run;
    int    tests_failed;
    int    held_credits;     // Records received, credit not yet returned
    int    total_presented;  // Since last reset
    int    total_returned;
    bit    timed_out;

    core_top UUT (
        .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data, .ret_credit,
        .ret_valid, .ret_id, .ret_pc, .ret_we, .ret_rd, .ret_wdata, .halted
    );

    always #2 clk = ~clk;  // 4 ns period

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        run        = 1'b0;
        prog_we    = 1'b0;
        ret_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < `NREGS; r++) mregs[r] = '0;  // Register file clears on reset
        held_credits    = 0;
        total_presented = 0;
        total_returned  = 0;
    endtask

    // Random program, loads only from words this program already stored
    task automatic gen_program(input bit dense);
        logic [`DMEM_DEPTH-1:0] written;
        reg_idx_t               last_rd;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        opcode_e                op;
        logic [5:0]             imm;
        int                     kind;
        int                     start;
        int                     a;
        bit                     found;
        written  = '0;
        last_rd  = 3'd1;
        prog_len = $urandom_range(20, 40);
        for (int i = 0; i < prog_len - 1; i++) begin
            kind = dense ? $urandom_range(0, 9) : $urandom_range(0, 6);
            if (kind > 6) kind = kind - 7;  // Dense programs lean on ALU ops
            rd  = reg_idx_t'(dense ? $urandom_range(1, 7) : $urandom_range(0, 7));
            rs1 = reg_idx_t'($urandom_range(0, 7));
            rs2 = reg_idx_t'($urandom_range(0, 7));
            if (dense && $urandom_range(0, 3) != 0) rs1 = last_rd;  // Back-to-back RAW
            if (dense && $urandom_range(0, 1) != 0) rs2 = last_rd;
            imm = 6'($urandom_range(0, 63));
            op  = opcode_e'(kind);
            if (op == OP_LD && written == '0) op = OP_ADDI;
            case (op)
                OP_LD: begin
                    start = $urandom_range(0, `DMEM_DEPTH - 1);
                    found = 1'b0;
                    for (int k = 0; k < `DMEM_DEPTH; k++) begin
                        a = (start + k) % `DMEM_DEPTH;
                        if (!found && written[a]) begin
                            imm   = 6'(a);
                            found = 1'b1;
                        end
                    end
                    prog[i] = {op, rd, 3'd0, imm};  // r0 base
                end
                OP_ST: begin
                    imm          = 6'($urandom_range(0, `DMEM_DEPTH - 1));
                    written[imm] = 1'b1;
                    prog[i]      = {op, (dense ? last_rd : rs2), 3'd0, imm};  // rd holds data
                end
                OP_ADDI: prog[i] = {op, rd, rs1, imm};
                default: prog[i] = {op, rd, rs1, rs2, 3'b000};
            endcase
            if (op != OP_ST && rd != '0) last_rd = rd;
        end
        prog[prog_len - 1] = {OP_HALT, 12'h000};
    endtask

    ////////////////////
    // ISA model
    ////////////////////
    task automatic build_expected();
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] res;
        opcode_e          op;
        reg_idx_t         rd;
        for (int i = 0; i < prog_len; i++) begin
            word = prog[i];
            op   = opcode_e'(word[15:12]);
            rd   = word[11:9];
            a    = mregs[word[8:6]];
            b    = mregs[word[5:3]];
            imm  = {{(`XLEN-6){word[5]}}, word[5:0]};  // Sign-extended 6-bit field
            res  = '0;
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + imm;
                OP_LD:   res = mdmem[(a + imm) % `DMEM_DEPTH];
                OP_ST: begin
                    res = mregs[rd];  // Record shows the stored value
                    mdmem[(a + imm) % `DMEM_DEPTH] = res;
                end
                default: ;
            endcase
            exp_pc[i]    = pc_t'(i);
            exp_rd[i]    = rd;
            exp_wdata[i] = res;
            exp_chk[i]   = (op != OP_HALT);
            exp_we[i]    = 1'b0;
            if (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD} && rd != '0) begin
                exp_we[i] = 1'b1;
                mregs[rd] = res;
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    ////////////////////
    // Run and collect
    ////////////////////
    // Stops at halted, or after stop_at records when non-zero
    task automatic run_program(input int mode, input int stop_at);
        int cycles;
        int idx;
        int stall_left;
        int starve_cnt;
        bit done;
        bit give;
        bit starving;
        cycles     = 0;
        idx        = 0;
        stall_left = 0;
        starve_cnt = 0;
        done       = 1'b0;
        starving   = (mode == MODE_STARVED);
        timed_out  = 1'b0;
        @(negedge clk);
        run = 1'b1;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            ret_credit = 1'b0;
            if (halted) begin
                done = 1'b1;
            end else begin
                if (ret_valid) begin
                    total_presented++;
                    if (total_presented > `RET_CREDITS + total_returned) begin
                        $display("record presented without a credit in test %s", test_name);
                        test_errs++;
                    end
                    if (idx < prog_len) begin
                        check_value("ret_id", idx, ret_id);
                        check_value("ret_pc", exp_pc[idx], ret_pc);
                        check_value("ret_we", exp_we[idx], ret_we);
                        check_value("ret_rd", exp_rd[idx], ret_rd);
                        if (exp_chk[idx]) check_value("ret_wdata", exp_wdata[idx], ret_wdata);
                    end else begin
                        $display("record past the end of the program in test %s", test_name);
                        test_errs++;
                    end
                    idx++;
                    held_credits++;
                    if (stop_at != 0 && idx == stop_at) done = 1'b1;
                end
                give = (held_credits > 0);
                if (starving) begin
                    give = 1'b0;
                    if (idx >= `RET_CREDITS) starve_cnt++;
                    if (starve_cnt == STARVE_CYCLES) begin  // Drought over, check and resume
                        check_value("records while starved", `RET_CREDITS, idx);
                        check_value("halted while starved", 0, halted);
                        starving = 1'b0;
                    end
                end else if (mode == MODE_BACKPRESS) begin
                    if (stall_left > 0) begin
                        stall_left--;
                        give = 1'b0;
                    end else if ($urandom_range(0, 5) == 0) begin
                        stall_left = $urandom_range(3, 15);  // Withhold for a stretch
                        give       = 1'b0;
                    end
                end
                if (give) begin
                    ret_credit = 1'b1;
                    held_credits--;
                    total_returned++;
                end
            end
        end
        if (!done) begin
            $display("timed out waiting for halted in test %s after %0d records",
                     test_name, idx);
            test_errs++;
            timed_out = 1'b1;
        end else if (stop_at == 0) begin
            check_value("record count", prog_len, idx);
        end
    endtask

    // Hand back all credits, then drop run
    task automatic end_run();
        int cycles;
        while (held_credits > 0) begin
            @(negedge clk);
            ret_credit = 1'b1;
            held_credits--;
            total_returned++;
        end
        @(negedge clk);
        ret_credit = 1'b0;
        check_value("halted before run fell", 1, halted);
        run    = 1'b0;
        cycles = 0;
        while (halted && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (halted) begin
            $display("halted stayed high after run fell in test %s", test_name);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic run_test(input string name, input bit dense, input int mode);
        test_name = name;
        test_errs = 0;
        gen_program(dense);
        build_expected();
        load_program();
        run_program(mode, 0);
        if (timed_out) apply_reset();  // Recover for the next test
        else end_run();
        finish_test();
    endtask

    task automatic mid_run_reset_test();
        test_name = "mid_run_reset";
        test_errs = 0;
        gen_program(1'b0);
        build_expected();
        load_program();
        run_program(MODE_PROMPT, 6);
        if (!timed_out) begin
            apply_reset();
            @(negedge clk);
            check_value("ret_valid after reset", 0, ret_valid);
            check_value("halted after reset", 0, halted);
            gen_program(1'b1);  // Reloaded program from clean registers
            build_expected();
            load_program();
            run_program(MODE_BACKPRESS, 0);
        end
        if (timed_out) apply_reset();
        else end_run();
        finish_test();
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        run             = 1'b0;
        prog_we         = 1'b0;
        prog_addr       = '0;
        prog_data       = '0;
        ret_credit      = 1'b0;
        tests_run       = 0;
        tests_failed    = 0;
        held_credits    = 0;
        total_presented = 0;
        total_returned  = 0;
        timed_out       = 1'b0;
        void'($urandom(32'h08ee_ef39));
        apply_reset();
        run_test("random_a", 1'b0, MODE_PROMPT);
        run_test("random_b", 1'b0, MODE_PROMPT);
        run_test("dense_a", 1'b1, MODE_PROMPT);
        run_test("dense_b", 1'b1, MODE_PROMPT);
        run_test("backpressure", 1'b0, MODE_BACKPRESS);
        run_test("backpressure_dense", 1'b1, MODE_BACKPRESS);
        run_test("credit_starved", 1'b0, MODE_STARVED);
        run_test("credit_starved_dense", 1'b1, MODE_STARVED);
        mid_run_reset_test();
        run_test("after_reset", 1'b0, MODE_PROMPT);
        $display("tests %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
// Processor top level
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module core_top
    import isa_pkg::*;
    import trace_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             prog_we,
    input  pc_t              prog_addr,
    input  logic [`XLEN-1:0] prog_data,
    input  logic             ret_credit,
    output logic             ret_valid,
    output seq_id_t          ret_id,
    output pc_t              ret_pc,
    output logic             ret_we,
    output reg_idx_t         ret_rd,
    output logic [`XLEN-1:0] ret_wdata,
    output logic             halted
);

    logic             dec_valid;
    instr_u           dec_instr;
    logic             dec_hold;
    logic             freeze;
    reg_idx_t         rf_ra1;
    reg_idx_t         rf_ra2;
    logic [`XLEN-1:0] rf_rd1;
    logic [`XLEN-1:0] rf_rd2;
    logic             ex_valid;
    reg_idx_t         ex_rd;
    logic             ex_wr;
    logic             mem_valid;
    reg_idx_t         mem_rd;
    logic             mem_wr;
    logic             fetch_fire;
    logic             wb_valid;
    pc_t              wb_pc;
    logic             wb_we;
    reg_idx_t         wb_rd;
    logic [`XLEN-1:0] wb_wdata;
    logic             wb_halt;

    pipe_core u_core (
        .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
        .dec_hold, .freeze, .rf_rd1, .rf_rd2,
        .dec_valid, .dec_instr, .rf_ra1, .rf_ra2,
        .ex_valid, .ex_rd, .ex_wr, .mem_valid, .mem_rd, .mem_wr,
        .fetch_fire, .wb_valid, .wb_pc, .wb_we, .wb_rd, .wb_wdata, .wb_halt
    );

    hazard_unit u_hazard (
        .dec_valid, .dec_instr, .ex_valid, .ex_rd, .ex_wr,
        .mem_valid, .mem_rd, .mem_wr, .dec_hold
    );

    // No register write commits while the retire port is out of credit
    regfile u_rf (
        .clk, .rst_n,
        .ra1 (rf_ra1),
        .ra2 (rf_ra2),
        .we  (wb_valid && wb_we && !freeze),
        .wa  (wb_rd),
        .wd  (wb_wdata),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2)
    );

    trace_unit u_trace (
        .clk, .rst_n, .run, .fetch_fire, .dec_hold,
        .wb_valid, .wb_pc, .wb_we, .wb_rd, .wb_wdata, .wb_halt, .ret_credit,
        .freeze, .ret_valid, .ret_id, .ret_pc, .ret_we, .ret_rd, .ret_wdata, .halted
    );

endmodule

`default_nettype wire

// ==== trace/trace_unit.sv ====
// Pipeline trace and retire port
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module trace_unit
    import isa_pkg::*;
    import trace_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             fetch_fire,
    input  logic             dec_hold,
    input  logic             wb_valid,
    input  pc_t              wb_pc,
    input  logic             wb_we,
    input  reg_idx_t         wb_rd,
    input  logic [`XLEN-1:0] wb_wdata,
    input  logic             wb_halt,
    input  logic             ret_credit,  // One pulse per returned credit
    output logic             freeze,
    output logic             ret_valid,
    output seq_id_t          ret_id,
    output pc_t              ret_pc,
    output logic             ret_we,
    output reg_idx_t         ret_rd,
    output logic [`XLEN-1:0] ret_wdata,
    output logic             halted
);

    logic        run_q;
    seq_id_t     fetch_id;    // Next id handed to fetch
    seq_id_t     dec_id;
    seq_id_t     ex_id;
    seq_id_t     mem_id;
    seq_id_t     wb_id;
    logic        dec_v;
    logic        ex_v;
    logic        mem_v;
    logic        wb_v;
    credit_cnt_t credits;

    ////////////////////
    // Shadow id pipeline
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            fetch_id <= '0;
            dec_v    <= 1'b0;
            ex_v     <= 1'b0;
            mem_v    <= 1'b0;
            wb_v     <= 1'b0;
        end else begin
            run_q <= run;
            if (run && !run_q) fetch_id <= '0;          // New program, ids from 0
            else if (fetch_fire) fetch_id <= fetch_id + 1'b1;
            if (!freeze) begin                          // Frozen core, frozen shadow
                if (!dec_hold) dec_v <= fetch_fire;
                ex_v  <= dec_v && !dec_hold;            // Hold leaves a bubble
                mem_v <= ex_v;
                wb_v  <= mem_v;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) dec_id <= fetch_id;
        if (!freeze) begin
            ex_id  <= dec_id;
            mem_id <= ex_id;
            wb_id  <= mem_id;
        end
    end

    ////////////////////
    // Credits and record
    ////////////////////
    assign freeze    = credits == '0;
    assign ret_valid = wb_valid && !freeze;  // Spends one credit
    assign ret_id    = wb_id;
    assign ret_pc    = wb_pc;
    assign ret_we    = wb_we;
    assign ret_rd    = wb_rd;
    assign ret_wdata = wb_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= credit_cnt_t'(`RET_CREDITS);
            halted  <= 1'b0;
        end else begin
            credits <= credits + credit_cnt_t'(ret_credit) - credit_cnt_t'(ret_valid);
            if (!run) halted <= 1'b0;
            else if (ret_valid && wb_halt) halted <= 1'b1;  // Sticky until run drops
        end
    end

    // Shadow must track the real stage valids through holds and freezes
    a_wb_tracks: assert property (@(posedge clk) disable iff (!rst_n) wb_v == wb_valid)
        else $error("shadow write-back valid out of step with the core");

    // Consumer returns no more than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= credit_cnt_t'(`RET_CREDITS))
        else $error("credit count above limit");

endmodule

`default_nettype wire

// ==== pipeline/pipe_core.sv ====
// Five-stage pipeline datapath
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module pipe_core
    import isa_pkg::*;
    import trace_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,         // Low means idle and programmable
    input  logic             prog_we,
    input  pc_t              prog_addr,
    input  logic [`XLEN-1:0] prog_data,
    input  logic             dec_hold,    // From hazard unit
    input  logic             freeze,      // From trace unit, no credits left
    input  logic [`XLEN-1:0] rf_rd1,
    input  logic [`XLEN-1:0] rf_rd2,
    output logic             dec_valid,
    output instr_u           dec_instr,
    output reg_idx_t         rf_ra1,
    output reg_idx_t         rf_ra2,
    output logic             ex_valid,
    output reg_idx_t         ex_rd,
    output logic             ex_wr,
    output logic             mem_valid,
    output reg_idx_t         mem_rd,
    output logic             mem_wr,
    output logic             fetch_fire,  // Fetch accepted into decode
    output logic             wb_valid,
    output pc_t              wb_pc,
    output logic             wb_we,
    output reg_idx_t         wb_rd,
    output logic [`XLEN-1:0] wb_wdata,
    output logic             wb_halt
);

    localparam int DA_W = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] dmem [`DMEM_DEPTH];

    pc_t              pc;
    logic             fetching;   // Between start and HALT fetch
    logic             armed;      // Waiting for run to start a program
    instr_u           fetch_word;
    pc_t              dec_pc;
    opcode_e          ex_op;
    pc_t              ex_pc;
    logic [`XLEN-1:0] ex_a;
    logic [`XLEN-1:0] ex_b;       // rs2, or store data for ST
    logic [`XLEN-1:0] ex_imm;
    logic [`XLEN-1:0] ex_res;
    opcode_e          mem_op;
    pc_t              mem_pc;
    logic [`XLEN-1:0] mem_res;
    logic [`XLEN-1:0] mem_sdata;
    logic [DA_W-1:0]  mem_addr;
    logic [`XLEN-1:0] mem_ld;

    ////////////////////
    // Fetch
    ////////////////////
    always_ff @(posedge clk) begin
        if (prog_we && !run) imem[prog_addr] <= prog_data;  // Program port, idle only
    end

    assign fetch_word = imem[pc];
    assign fetch_fire = fetching && !dec_hold && !freeze;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            fetching  <= 1'b0;
            armed     <= 1'b1;
            dec_valid <= 1'b0;
        end else begin
            if (!run) begin
                armed    <= 1'b1;
                fetching <= 1'b0;
            end else if (armed && !freeze) begin
                armed    <= 1'b0;  // Restart at address 0
                fetching <= 1'b1;
                pc       <= '0;
            end else if (fetch_fire) begin
                pc <= pc + 1'b1;
                if (fetch_word.r_form.op == OP_HALT) fetching <= 1'b0;  // Nothing after HALT
            end
            if (fetch_fire) dec_valid <= 1'b1;
            else if (!dec_hold && !freeze) dec_valid <= 1'b0;  // Decode drained
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            dec_instr <= fetch_word;
            dec_pc    <= pc;
        end
    end

    ////////////////////
    // Decode
    ////////////////////
    assign rf_ra1 = dec_instr.r_form.rs1;
    assign rf_ra2 = src2_of(dec_instr);

    always_ff @(posedge clk) begin
        if (!rst_n) ex_valid <= 1'b0;
        else if (!freeze) ex_valid <= dec_valid && !dec_hold;  // Bubble on hold
    end

    always_ff @(posedge clk) begin
        if (!freeze && dec_valid && !dec_hold) begin
            ex_op  <= dec_instr.r_form.op;
            ex_rd  <= dec_instr.r_form.rd;
            ex_wr  <= writes_rd(dec_instr.r_form.op) && dec_instr.r_form.rd != '0;
            ex_a   <= rf_rd1;
            ex_b   <= rf_rd2;
            ex_imm <= sext_imm(dec_instr);
            ex_pc  <= dec_pc;
        end
    end

    ////////////////////
    // Execute
    ////////////////////
    always_comb begin
        case (ex_op)
            OP_ADD:                ex_res = ex_a + ex_b;
            OP_SUB:                ex_res = ex_a - ex_b;
            OP_AND:                ex_res = ex_a & ex_b;
            OP_XOR:                ex_res = ex_a ^ ex_b;
            OP_ADDI, OP_LD, OP_ST: ex_res = ex_a + ex_imm;  // Sum or data address
            default:               ex_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) mem_valid <= 1'b0;
        else if (!freeze) mem_valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mem_op    <= ex_op;
            mem_rd    <= ex_rd;
            mem_wr    <= ex_wr;
            mem_res   <= ex_res;
            mem_sdata <= ex_b;
            mem_pc    <= ex_pc;
        end
    end

    ////////////////////
    // Memory
    ////////////////////
    assign mem_addr = mem_res[DA_W-1:0];  // Wraps inside the small array
    assign mem_ld   = dmem[mem_addr];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_op == OP_ST && !freeze) dmem[mem_addr] <= mem_sdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) wb_valid <= 1'b0;
        else if (!freeze) wb_valid <= mem_valid;
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            wb_pc   <= mem_pc;
            wb_we   <= mem_wr;
            wb_rd   <= mem_rd;
            wb_halt <= mem_op == OP_HALT;
            case (mem_op)
                OP_LD:   wb_wdata <= mem_ld;
                OP_ST:   wb_wdata <= mem_sdata;  // Stored value shown in the record
                default: wb_wdata <= mem_res;
            endcase
        end
    end

    // Freeze comes from the credit counter in the trace unit
    a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) freeze |=> $stable(pc))
        else $error("PC changed under freeze");

endmodule

`default_nettype wire

// ==== pipeline/hazard_unit.sv ====
// Read-after-write stall detection
`timescale 1ns/10ps
`default_nettype none

module hazard_unit
    import isa_pkg::*;
(
    input  logic     dec_valid,
    input  instr_u   dec_instr,
    input  logic     ex_valid,
    input  reg_idx_t ex_rd,
    input  logic     ex_wr,
    input  logic     mem_valid,
    input  reg_idx_t mem_rd,
    input  logic     mem_wr,
    output logic     dec_hold   // Hold fetch and decode, bubble into execute
);

    logic     use1;   // rs1 is read
    logic     use2;   // rs2, or rd for ST, is read
    reg_idx_t src2;
    logic     hit1;
    logic     hit2;

    // Which operand fields the opcode reads
    always_comb begin
        use1 = 1'b0;
        use2 = 1'b0;
        case (dec_instr.r_form.op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ST: begin
                use1 = 1'b1;
                use2 = 1'b1;
            end
            OP_ADDI, OP_LD: use1 = 1'b1;
            default: ;  // HALT reads nothing
        endcase
    end

    assign src2 = src2_of(dec_instr);

    // r0 is constant, never a dependency
    function automatic logic raw(reg_idx_t src, logic used, logic v, logic wr, reg_idx_t rd);
        return used && src != '0 && v && wr && src == rd;
    endfunction

    assign hit1 = raw(dec_instr.r_form.rs1, use1, ex_valid, ex_wr, ex_rd) ||
                  raw(dec_instr.r_form.rs1, use1, mem_valid, mem_wr, mem_rd);
    assign hit2 = raw(src2, use2, ex_valid, ex_wr, ex_rd) ||
                  raw(src2, use2, mem_valid, mem_wr, mem_rd);

    assign dec_hold = dec_valid && (hit1 || hit2);

endmodule

`default_nettype wire

// ==== pipeline/regfile.sv ====
// Register file
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module regfile
    import isa_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  reg_idx_t         ra1,
    input  reg_idx_t         ra2,
    input  logic             we,    // Already gated by freeze
    input  reg_idx_t         wa,
    input  logic [`XLEN-1:0] wd,
    output logic [`XLEN-1:0] rd1,
    output logic [`XLEN-1:0] rd2
);

    logic [`XLEN-1:0] regs [`NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so write-back never stalls decode
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

    // Decode must strip r0 destinations before they reach write-back
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n) !(we && wa == '0))
        else $error("register write aimed at r0");

endmodule

`default_nettype wire

// ==== common/trace_pkg.sv ====
// Retire trace types
`default_nettype none
`include "cpu_defs.svh"

package trace_pkg;

    // Program order tag, restarts at each run
    typedef logic [`SEQ_W-1:0] seq_id_t;

    // Outstanding consumer credits, 0 up to RET_CREDITS
    typedef logic [2:0] credit_cnt_t;

    // Instruction address carried with each record
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] pc_t;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
// Toy ISA encodings
`default_nettype none
`include "cpu_defs.svh"

package isa_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_ADDI,
        OP_LD,
        OP_ST,
        OP_HALT
    } opcode_e;

    typedef logic [2:0] reg_idx_t;

    // Register-register view
    typedef struct packed {
        opcode_e    op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] unused;
    } r_form_t;

    // Immediate view, also LD and ST
    typedef struct packed {
        opcode_e           op;
        reg_idx_t          rd;   // Store data register for ST
        reg_idx_t          rs1;
        logic signed [5:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_u;

    // Immediate widened to a data word
    function automatic logic [`XLEN-1:0] sext_imm(instr_u i);
        return {{(`XLEN-6){i.i_form.imm[5]}}, i.i_form.imm};
    endfunction

    // Second source register, ST reads its data from the rd field
    function automatic reg_idx_t src2_of(instr_u i);
        return (i.r_form.op == OP_ST) ? i.r_form.rd : i.r_form.rs2;
    endfunction

    function automatic logic writes_rd(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD};
    endfunction

endpackage

`default_nettype wire

// ==== common/cpu_defs.svh ====
// Core width and depth constants
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////
// Datapath
////////////////////
`define XLEN        16  // Data and instruction word width
`define NREGS       8   // Architectural registers, r0 reads zero

////////////////////
// Memories
////////////////////
`define IMEM_DEPTH  64  // Instruction words
`define DMEM_DEPTH  16  // Data words

////////////////////
// Retire trace
////////////////////
`define RET_CREDITS 4   // Credits held by the retire consumer after reset
`define SEQ_W       8   // Sequence id width, wraps

`endif
